/* common/isaPkg.sv */
`default_nettype none

package isaPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int immWidth = 16;
	localparam int targetWidth = 26;
	localparam logic [dataWidth-1:0] resetPc = 32'hbfc00000;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	// Major opcodes where special covers register-register and shifts
	typedef enum logic [5:0] {
		opSpecial = 6'b000000,
		opJ       = 6'b000010,
		opBeq     = 6'b000100,
		opBne     = 6'b000101,
		opAddiu   = 6'b001001,
		opSlti    = 6'b001010,
		opSltiu   = 6'b001011,
		opAndi    = 6'b001100,
		opOri     = 6'b001101,
		opXori    = 6'b001110,
		opLui     = 6'b001111,
		opLb      = 6'b100000,
		opLw      = 6'b100011,
		opLbu     = 6'b100100,
		opSb      = 6'b101000,
		opSw      = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		fnSll  = 6'b000000,
		fnSrl  = 6'b000010,
		fnSra  = 6'b000011,
		fnAddu = 6'b100001,
		fnSubu = 6'b100011,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnNor  = 6'b100111,
		fnSlt  = 6'b101010,
		fnSltu = 6'b101011
	} funct_t;

	// R-type layout; immediate is bits 15:0 and jump target bits 25:0
	typedef struct packed {
		opcode_t opcode;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [4:0] shamt;
		funct_t funct;
	} instr_t;

endpackage

`default_nettype wire

/* common/coreCtrlPkg.sv */
`default_nettype none

package coreCtrlPkg;

	import isaPkg::*;

	typedef enum logic [2:0] {
		Fetch,
		Decode,
		Execute,
		Load,
		Store,
		Writeback
	} coreState_t;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluPassB
	} aluOp_t;

	typedef enum logic [1:0] {
		memNone,
		memByte,
		memWord
	} memSize_t;

	// Source of the ALU B operand
	typedef enum logic [1:0] {
		bReg,
		bSignImm,
		bZeroImm
	} bSel_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic shiftByImm;
		bSel_t bSel;
		logic destIsRd;
		logic regWrite;
		logic memToReg;
		logic isLoad;
		logic isStore;
		memSize_t memSize;
		logic loadSigned;
		logic upperImm;
		logic branchEq;
		logic branchNe;
		logic jump;
	} ctrlWord_t;

	typedef struct packed {
		logic en;
		word_t addr;
	} instReq_t;

	typedef struct packed {
		logic en;
		logic [3:0] wen;
		word_t addr;
		word_t wdata;
	} dataReq_t;

	typedef struct packed {
		word_t pc;
		logic [3:0] wen;
		regAddr_t wnum;
		word_t wdata;
	} wbTrace_t;

endpackage

`default_nettype wire

/* control/controlFsm.sv */
`default_nettype none

module controlFsm (
	input wire logic clk,
	input wire logic resetn,
	input wire isaPkg::instr_t instr,
	output coreCtrlPkg::coreState_t state,
	output coreCtrlPkg::ctrlWord_t ctrl,
	output logic pcLoad
);

	import isaPkg::*;
	import coreCtrlPkg::*;

	coreState_t nextState;
	ctrlWord_t decoded;

	always_ff @(posedge clk)
	begin
		if (!resetn)
			state <= Fetch;
		else
			state <= nextState;
	end

	always_comb
	begin
		case (state)
			Fetch: nextState = Decode;
			Decode: nextState = Execute;
			Execute:
			begin
				if (ctrl.isLoad)
					nextState = Load;
				else if (ctrl.isStore)
					nextState = Store;
				else if (ctrl.regWrite)
					nextState = Writeback;
				else
					// branches, jumps and undecoded words end here
					nextState = Fetch;
			end
			Load: nextState = Writeback;
			default: nextState = Fetch;
		endcase
	end

	// PC moves once per instruction
	assign pcLoad = (state == Execute);

	always_comb
	begin
		decoded = '0;
		case (instr.opcode)
			opSpecial:
			begin
				decoded.destIsRd = 1'b1;
				decoded.regWrite = 1'b1;
				case (instr.funct)
					fnAddu: decoded.aluOp = aluAdd;
					fnSubu: decoded.aluOp = aluSub;
					fnAnd: decoded.aluOp = aluAnd;
					fnOr: decoded.aluOp = aluOr;
					fnXor: decoded.aluOp = aluXor;
					fnNor: decoded.aluOp = aluNor;
					fnSlt: decoded.aluOp = aluSlt;
					fnSltu: decoded.aluOp = aluSltu;
					fnSll, fnSrl, fnSra:
					begin
						decoded.shiftByImm = 1'b1;
						decoded.aluOp = (instr.funct == fnSll) ? aluSll :
							(instr.funct == fnSrl) ? aluSrl : aluSra;
					end
					default: decoded = '0;
				endcase
			end
			opAddiu, opSlti, opSltiu:
			begin
				decoded.regWrite = 1'b1;
				decoded.bSel = bSignImm;
				decoded.aluOp = (instr.opcode == opAddiu) ? aluAdd :
					(instr.opcode == opSlti) ? aluSlt : aluSltu;
			end
			opAndi, opOri, opXori:
			begin
				decoded.regWrite = 1'b1;
				decoded.bSel = bZeroImm;
				decoded.aluOp = (instr.opcode == opAndi) ? aluAnd :
					(instr.opcode == opOri) ? aluOr : aluXor;
			end
			opLui:
			begin
				decoded.regWrite = 1'b1;
				decoded.bSel = bZeroImm;
				decoded.aluOp = aluPassB;
				decoded.upperImm = 1'b1;
			end
			opLw, opLb, opLbu:
			begin
				decoded.bSel = bSignImm;
				decoded.isLoad = 1'b1;
				decoded.memToReg = 1'b1;
				decoded.regWrite = 1'b1;
				decoded.memSize = (instr.opcode == opLw) ? memWord : memByte;
				decoded.loadSigned = (instr.opcode == opLb);
			end
			opSw, opSb:
			begin
				decoded.bSel = bSignImm;
				decoded.isStore = 1'b1;
				decoded.memSize = (instr.opcode == opSw) ? memWord : memByte;
			end
			opBeq, opBne:
			begin
				decoded.aluOp = aluSub;
				decoded.branchEq = (instr.opcode == opBeq);
				decoded.branchNe = (instr.opcode == opBne);
			end
			opJ: decoded.jump = 1'b1;
			default: decoded = '0;
		endcase
	end

	// Captured at end of Decode and dropped on the way back to Fetch
	always_ff @(posedge clk)
	begin
		if (!resetn)
			ctrl <= '0;
		else if (state == Decode)
			ctrl <= decoded;
		else if (nextState == Fetch)
			ctrl <= '0;
	end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic resetn,
	input wire isaPkg::regAddr_t raddr1,
	input wire isaPkg::regAddr_t raddr2,
	output isaPkg::word_t rdata1,
	output isaPkg::word_t rdata2,
	input wire logic wen,
	input wire isaPkg::regAddr_t waddr,
	input wire isaPkg::word_t wdata
);

	import isaPkg::*;

	localparam int numRegs = 2 ** regAddrWidth;

	word_t regs [1:numRegs-1];

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			for (int i = 1; i < numRegs; i++)
				regs[i] <= '0;
		end
		else if (wen && (waddr != '0))
			regs[waddr] <= wdata;
	end

	// Register zero reads as zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hdl/aluUnit.sv */
`default_nettype none

module aluUnit (
	input wire coreCtrlPkg::aluOp_t op,
	input wire isaPkg::word_t a,
	input wire isaPkg::word_t b,
	output isaPkg::word_t result,
	output logic zero
);

	import coreCtrlPkg::*;

	logic [4:0] shiftAmt;

	assign shiftAmt = a[4:0];

	always_comb
	begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluNor: result = ~(a | b);
			aluSlt: result = {31'd0, $signed(a) < $signed(b)};
			aluSltu: result = {31'd0, a < b};
			// shifts act on b, the rt operand
			aluSll: result = b << shiftAmt;
			aluSrl: result = b >> shiftAmt;
			aluSra: result = $signed(b) >>> shiftAmt;
			aluPassB: result = b;
			default: result = '0;
		endcase
	end

	// Used by beq and bne after a subtract
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/memAlign.sv */
`default_nettype none

module memAlign (
	input wire logic [1:0] offset,
	input wire coreCtrlPkg::memSize_t size,
	input wire logic loadSigned,
	input wire isaPkg::word_t storeData,
	input wire isaPkg::word_t rawLoad,
	output isaPkg::word_t loadWord,
	output logic [3:0] storeWen,
	output isaPkg::word_t storeWdata
);

	import isaPkg::*;
	import coreCtrlPkg::*;

	logic [7:0] laneByte;
	logic extBit;

	always_comb
	begin
		case (offset)
			2'd0: laneByte = rawLoad[7:0];
			2'd1: laneByte = rawLoad[15:8];
			2'd2: laneByte = rawLoad[23:16];
			default: laneByte = rawLoad[31:24];
		endcase
	end

	assign extBit = loadSigned & laneByte[7];

	assign loadWord = (size == memByte) ? {{(dataWidth - 8){extBit}}, laneByte} : rawLoad;

	// Byte stores go out on every lane and the strobe picks the one that lands
	always_comb
	begin
		case (size)
			memByte:
			begin
				storeWen = 4'b0001 << offset;
				storeWdata = {4{storeData[7:0]}};
			end
			memWord:
			begin
				storeWen = 4'b1111;
				storeWdata = storeData;
			end
			default:
			begin
				storeWen = 4'b0000;
				storeWdata = storeData;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/cpuCore.sv */
`default_nettype none

module cpuCore (
	input wire logic clk,
	input wire logic resetn,
	output coreCtrlPkg::instReq_t instReq,
	input wire isaPkg::word_t instRdata,
	output coreCtrlPkg::dataReq_t dataReq,
	input wire isaPkg::word_t dataRdata,
	output coreCtrlPkg::wbTrace_t trace
);

	import isaPkg::*;
	import coreCtrlPkg::*;

	coreState_t state;
	ctrlWord_t ctrl;
	logic pcLoad;

	word_t pc;
	word_t instPc;
	instr_t instReg;
	instr_t decodeInstr;
	word_t aluReg;

	word_t rdata1;
	word_t rdata2;
	word_t aluA;
	word_t aluB;
	word_t aluResult;
	logic aluZero;
	word_t loadWord;
	logic [3:0] storeWen;
	word_t storeWdata;

	logic [immWidth-1:0] imm;
	word_t pcPlus4;
	word_t branchTarget;
	word_t jumpTarget;
	word_t nextPc;
	logic branchTaken;
	regAddr_t destReg;
	word_t wbData;

	// Fetched word is valid on instRdata during Decode
	assign decodeInstr = (state == Decode) ? instr_t'(instRdata) : instReg;

	controlFsm i_controlFsm (
		.clk(clk),
		.resetn(resetn),
		.instr(decodeInstr),
		.state(state),
		.ctrl(ctrl),
		.pcLoad(pcLoad)
	);

	always_ff @(posedge clk)
	begin
		if (!resetn)
			pc <= resetPc;
		else if (pcLoad)
			pc <= nextPc;
	end

	always_ff @(posedge clk)
	begin
		if (state == Decode)
		begin
			instReg <= instr_t'(instRdata);
			instPc <= pc;
		end
		if (state == Execute)
			aluReg <= aluResult;
	end

	regFile i_regFile (
		.clk(clk),
		.resetn(resetn),
		.raddr1(instReg.rs),
		.raddr2(instReg.rt),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.wen(state == Writeback),
		.waddr(destReg),
		.wdata(wbData)
	);

	assign imm = instReg[immWidth-1:0];

	assign aluA = ctrl.shiftByImm ? {{(dataWidth - $bits(instReg.shamt)){1'b0}}, instReg.shamt}
		: rdata1;

	always_comb
	begin
		case (ctrl.bSel)
			bSignImm: aluB = {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};
			bZeroImm: aluB = {{(dataWidth - immWidth){1'b0}}, imm};
			default: aluB = rdata2;
		endcase
	end

	aluUnit i_aluUnit (
		.op(ctrl.aluOp),
		.a(aluA),
		.b(aluB),
		.result(aluResult),
		.zero(aluZero)
	);

	// Next PC
	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + {{(dataWidth - immWidth - 2){imm[immWidth-1]}}, imm, 2'b00};
	assign jumpTarget = {pcPlus4[dataWidth-1:targetWidth+2], instReg[targetWidth-1:0], 2'b00};
	assign branchTaken = (ctrl.branchEq & aluZero) | (ctrl.branchNe & ~aluZero);
	assign nextPc = ctrl.jump ? jumpTarget : (branchTaken ? branchTarget : pcPlus4);

	memAlign i_memAlign (
		.offset(aluReg[1:0]),
		.size(ctrl.memSize),
		.loadSigned(ctrl.loadSigned),
		.storeData(rdata2),
		.rawLoad(dataRdata),
		.loadWord(loadWord),
		.storeWen(storeWen),
		.storeWdata(storeWdata)
	);

	assign destReg = ctrl.destIsRd ? instReg.rd : instReg.rt;

	// lui shifts its immediate into the upper half here
	assign wbData = ctrl.memToReg ? loadWord
		: (ctrl.upperImm ? {aluReg[immWidth-1:0], {immWidth{1'b0}}} : aluReg);

	assign instReq.en = (state == Fetch);
	assign instReq.addr = pc;

	assign dataReq.en = (state == Load) || (state == Store);
	assign dataReq.wen = (state == Store) ? storeWen : 4'b0000;
	assign dataReq.addr = aluReg;
	assign dataReq.wdata = storeWdata;

	assign trace.pc = instPc;
	assign trace.wen = {4{state == Writeback}};
	assign trace.wnum = destReg;
	assign trace.wdata = wbData;

endmodule

`default_nettype wire

/* tb/tbClock.sv */
`default_nettype none

module tbClock (
	output logic clk,
	output logic resetn
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int halfPeriod = 2;
	localparam int resetCycles = 8;

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Release on a falling edge
	initial
	begin
		resetn = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

`default_nettype wire

/* tb/cpuCoreTb.sv */
`default_nettype none

module cpuCoreTb;

	timeunit 1ns;
	timeprecision 100ps;

	import isaPkg::*;
	import coreCtrlPkg::*;

	localparam int memWords = 1024;
	localparam int numRandom = 200;
	localparam int loopIdx = 16 + numRandom;
	localparam int numInstr = loopIdx + 1;
	localparam int watchdogCycles = 6 * numInstr + 200;
	localparam int baseReg = 8;

	logic clk;
	logic resetn;
	instReq_t instReq;
	word_t instRdata;
	dataReq_t dataReq;
	word_t dataRdata;
	wbTrace_t trace;

	word_t imem [memWords];
	word_t dmem [memWords];
	// Shadow state for the reference model
	word_t refMem [memWords];
	word_t refRegs [32];

	wbTrace_t expQ [$];
	string expNameQ [$];
	int expCount;
	int recordsSeen;
	int errors;

	tbClock i_clock (
		.clk(clk),
		.resetn(resetn)
	);

	cpuCore i_dut (
		.clk(clk),
		.resetn(resetn),
		.instReq(instReq),
		.instRdata(instRdata),
		.dataReq(dataReq),
		.dataRdata(dataRdata),
		.trace(trace)
	);

	function automatic word_t fillWord(input int idx);
		return (32'(idx) * 32'h9e3779b9) ^ 32'h5a5a0000;
	endfunction

	function automatic word_t makeRType(input logic [5:0] fn, input int rs, input int rt,
		input int rd, input int shamt);
		return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
	endfunction

	function automatic word_t makeIType(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic word_t makeJType(input int targetIdx);
		word_t addr;
		addr = resetPc + (32'(targetIdx) << 2);
		return {opJ, addr[27:2]};
	endfunction

	// Register 8 stays the data base so random writes avoid 1 to 8
	function automatic int pickDest();
		if ($urandom % 8 == 0)
			return 0;
		return 9 + ($urandom % 23);
	endfunction

	function automatic string mnemonic(input word_t ins);
		opcode_t op;
		funct_t fn;
		op = opcode_t'(ins[31:26]);
		fn = funct_t'(ins[5:0]);
		return (op == opSpecial) ? fn.name() : op.name();
	endfunction

	// Runs one instruction on the shadow state and returns 1 when it writes back
	function automatic bit refStep(input word_t pc, output wbTrace_t rec, output word_t nextPc,
		output string name);
		word_t ins;
		logic [5:0] op;
		logic [5:0] fn;
		int rs, rt, rd, shamt;
		int dest;
		int byteOff;
		word_t a, b, simm, zimm, addr, res;
		logic [7:0] ldByte;
		bit writes;
		ins = imem[pc[11:2]];
		op = ins[31:26];
		fn = ins[5:0];
		rs = int'(ins[25:21]);
		rt = int'(ins[20:16]);
		rd = int'(ins[15:11]);
		shamt = int'(ins[10:6]);
		a = refRegs[rs];
		b = refRegs[rt];
		simm = {{16{ins[15]}}, ins[15:0]};
		zimm = {16'h0000, ins[15:0]};
		addr = a + simm;
		byteOff = 8 * int'(addr[1:0]);
		ldByte = refMem[addr[11:2]][byteOff +: 8];
		name = mnemonic(ins);
		nextPc = pc + 32'd4;
		writes = 1'b1;
		dest = rt;
		res = '0;
		case (op)
			opSpecial:
			begin
				dest = rd;
				case (fn)
					fnAddu: res = a + b;
					fnSubu: res = a - b;
					fnAnd: res = a & b;
					fnOr: res = a | b;
					fnXor: res = a ^ b;
					fnNor: res = ~(a | b);
					fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					fnSltu: res = (a < b) ? 32'd1 : 32'd0;
					fnSll: res = b << shamt;
					fnSrl: res = b >> shamt;
					fnSra: res = $signed(b) >>> shamt;
					default: writes = 1'b0;
				endcase
			end
			opAddiu: res = a + simm;
			opSlti: res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
			opSltiu: res = (a < simm) ? 32'd1 : 32'd0;
			opAndi: res = a & zimm;
			opOri: res = a | zimm;
			opXori: res = a ^ zimm;
			opLui: res = {ins[15:0], 16'h0000};
			opLw: res = refMem[addr[11:2]];
			opLb: res = {{24{ldByte[7]}}, ldByte};
			opLbu: res = {24'h000000, ldByte};
			opSw:
			begin
				writes = 1'b0;
				refMem[addr[11:2]] = b;
			end
			opSb:
			begin
				writes = 1'b0;
				refMem[addr[11:2]][byteOff +: 8] = b[7:0];
			end
			opBeq:
			begin
				writes = 1'b0;
				if (a == b)
					nextPc = pc + 32'd4 + (simm << 2);
			end
			opBne:
			begin
				writes = 1'b0;
				if (a != b)
					nextPc = pc + 32'd4 + (simm << 2);
			end
			opJ:
			begin
				writes = 1'b0;
				nextPc = {nextPc[31:28], ins[25:0], 2'b00};
			end
			default: writes = 1'b0;
		endcase
		// r0 still shows the computed value on the trace
		if (writes && dest != 0)
			refRegs[dest] = res;
		rec.pc = pc;
		rec.wen = 4'hf;
		rec.wnum = 5'(dest);
		rec.wdata = res;
		return writes;
	endfunction

	task automatic buildProgram();
		word_t initVals [1:8];
		funct_t rrFn [8];
		funct_t shiftFn [3];
		opcode_t immOps [6];
		opcode_t loadOps [3];
		int idx;
		int kind;
		int rs, rt, rd;
		int k;
		initVals = '{32'h80000000, 32'h7fffffff, 32'hffffffff, 32'h12345678,
			32'h0000ff80, 32'hdeadbeef, 32'h00000005, 32'h00000400};
		rrFn = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
		shiftFn = '{fnSll, fnSrl, fnSra};
		immOps = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori};
		loadOps = '{opLw, opLb, opLbu};
		for (int i = 0; i < memWords; i++)
		begin
			imem[i] = {6'h3f, 10'(i), 16'h0000};
			dmem[i] = fillWord(i);
			refMem[i] = fillWord(i);
		end
		for (int i = 0; i < 32; i++)
			refRegs[i] = '0;
		idx = 0;
		for (int r = 1; r <= 8; r++)
		begin
			imem[idx] = makeIType(opLui, 0, r, initVals[r][31:16]);
			imem[idx + 1] = makeIType(opOri, r, r, initVals[r][15:0]);
			idx += 2;
		end
		for (int i = 0; i < numRandom; i++)
		begin
			kind = $urandom % 20;
			rs = $urandom % 32;
			rt = $urandom % 32;
			rd = pickDest();
			// Targets go forward and never past the final loop
			k = $urandom % 4;
			if (idx + 1 + k > loopIdx)
				k = loopIdx - idx - 1;
			case (kind)
				0, 1, 2, 3, 4: imem[idx] = makeRType(rrFn[$urandom % 8], rs, rt, rd, 0);
				5, 6: imem[idx] = makeRType(shiftFn[$urandom % 3], 0, rt, rd, $urandom % 32);
				7, 8, 9, 10: imem[idx] = makeIType(immOps[$urandom % 6], rs, rd, 16'($urandom));
				11: imem[idx] = makeIType(opLui, 0, rd, 16'($urandom));
				12, 13:
				begin
					k = $urandom % 3;
					if (k == 0)
						imem[idx] = makeIType(loadOps[k], baseReg, rd, 16'(($urandom % 16) * 4));
					else
						imem[idx] = makeIType(loadOps[k], baseReg, rd, 16'($urandom % 64));
				end
				14, 15:
				begin
					if ($urandom % 2 == 0)
						imem[idx] = makeIType(opSw, baseReg, rt, 16'(($urandom % 16) * 4));
					else
						imem[idx] = makeIType(opSb, baseReg, rt, 16'($urandom % 64));
				end
				16, 17:
				begin
					// Equal operands now and then so beq takes
					if ($urandom % 3 == 0)
						rt = rs;
					imem[idx] = makeIType(($urandom % 2 == 0) ? opBeq : opBne, rs, rt, 16'(k));
				end
				18: imem[idx] = makeJType(idx + 1 + k);
				default:
				begin
					if ($urandom % 2 == 0)
						imem[idx] = makeIType(6'h3f, rs, rt, 16'($urandom));
					else
						imem[idx] = makeRType(6'h08, rs, rt, rd, 0);
				end
			endcase
			idx++;
		end
		imem[loopIdx] = makeJType(loopIdx);
	endtask

	// SRAM models serve a request on the falling edge it is seen
	always @(negedge clk)
	begin
		if (instReq.en === 1'b1)
			instRdata <= imem[instReq.addr[11:2]];
		if (dataReq.en === 1'b1)
		begin
			if (dataReq.wen != 4'b0000)
			begin
				for (int i = 0; i < 4; i++)
					if (dataReq.wen[i])
						dmem[dataReq.addr[11:2]][8 * i +: 8] = dataReq.wdata[8 * i +: 8];
			end
			else
				dataRdata <= dmem[dataReq.addr[11:2]];
		end
	end

	always @(negedge clk)
	begin : compareTrace
		wbTrace_t want;
		string name;
		if (resetn && trace.wen == 4'hf)
		begin
			if (expQ.size() == 0)
			begin
				errors++;
				$display("Unexpected trace record from pc %h for r%0d, none was left to match",
					trace.pc, trace.wnum);
			end
			else
			begin
				want = expQ.pop_front();
				name = expNameQ.pop_front();
				if (trace.pc !== want.pc)
				begin
					errors++;
					$display("Error %s record %0d pc: expected %h, actual %h",
						name, recordsSeen, want.pc, trace.pc);
				end
				if (trace.wnum !== want.wnum)
				begin
					errors++;
					$display("Error %s record %0d wnum: expected %0d, actual %0d",
						name, recordsSeen, want.wnum, trace.wnum);
				end
				if (trace.wdata !== want.wdata)
				begin
					errors++;
					$display("Error %s record %0d wdata: expected %h, actual %h",
						name, recordsSeen, want.wdata, trace.wdata);
				end
				recordsSeen++;
			end
		end
	end

	initial
	begin : watchdog
		repeat (watchdogCycles) @(posedge clk);
		errors++;
		$display("Timeout: only %0d of %0d trace records arrived", recordsSeen, expCount);
		$display("Checks done: %0d records compared, %0d errors", recordsSeen, errors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin : mainFlow
		word_t pc;
		word_t nextPc;
		wbTrace_t rec;
		string name;
		int steps;
		instRdata = '0;
		dataRdata = '0;
		errors = 0;
		recordsSeen = 0;
		void'($urandom(45361));
		buildProgram();
		// Expected trace up to the jump-to-self at the end
		pc = resetPc;
		steps = 0;
		while (steps < memWords)
		begin
			if (refStep(pc, rec, nextPc, name))
			begin
				expQ.push_back(rec);
				expNameQ.push_back(name);
			end
			if (nextPc == pc)
				break;
			pc = nextPc;
			steps++;
		end
		expCount = expQ.size();
		while (recordsSeen < expCount)
			@(posedge clk);
		// Idle loop must stay silent
		repeat (20) @(posedge clk);
		$display("Checks done: %0d records compared, %0d errors", recordsSeen, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
common/isaPkg.sv
common/coreCtrlPkg.sv
control/controlFsm.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/memAlign.sv
hdl/cpuCore.sv
tb/tbClock.sv
tb/cpuCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --timing
SIM_FLAGS ?= --binary -Wno-fatal
TOP = cpuCoreTb
FILELIST = vlog.f
OBJ_DIR = obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
